// File: compile.f
+incdir+verif
logic/csr_pkg.sv
logic/trap_pkg.sv
logic/csr_decoder.sv
logic/stage_reg.sv
logic/irq_arbiter.sv
logic/csr_bank.sv
logic/csr_unit_top.sv
verif/csr_unit_tb.sv

// File: logic/csr_bank.sv
/* Machine CSR storage, masked write/set/clear, exception and
   interrupt entry, mret, mcycle and minstret counters */
module csr_bank
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        valid_i,
    input  logic        kill_i,
    input  csr_req_t    req_i,
    input  trap_event_t trap_i,
    input  logic        irq_ack_i,
    input  irq_code_e   irq_cause_i,
    input  logic [31:0] mip_i,
    output logic [31:0] rdata_o,
    output logic        rdata_valid_o,
    output logic [31:0] mie_o,
    output logic        global_ie_o,
    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o
);

    logic [31:0] mstatus;
    logic [31:0] misa;
    logic [31:0] mie;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [63:0] mcycle;
    logic [63:0] minstret;
    logic [31:0] cur_val;
    logic [31:0] wmask;
    logic [31:0] wr_data;
    logic [31:0] held_pc;
    priv_e       held_priv;
    logic        act;
    logic        rd_en;

    assign act   = valid_i && !kill_i;  // Held instruction survives this cycle
    assign rd_en = act && req_i.read && !req_i.rd_zero;  // No writeback to x0

    // Return point for interrupt entry, zero with an empty stage
    assign held_pc   = valid_i ? trap_i.pc : '0;
    assign held_priv = valid_i ? trap_i.priv : PRIV_MACHINE;

    assign mie_o       = mie;
    assign global_ie_o = mstatus[MSTATUS_MIE_BIT];
    assign mtvec_o     = mtvec;
    assign mepc_o      = mepc;

    // Current value and mask of the addressed register
    always_comb begin
        cur_val = '0;
        wmask   = '0;  // Unknown and read-only addresses take no writes
        case (req_i.addr)
            CSR_MSTATUS:  begin cur_val = mstatus;  wmask = MSTATUS_WMASK;  end
            CSR_MISA:     begin cur_val = misa;     wmask = MISA_WMASK;     end
            CSR_MIE:      begin cur_val = mie;      wmask = MIE_WMASK;      end
            CSR_MTVEC:    begin cur_val = mtvec;    wmask = MTVEC_WMASK;    end
            CSR_MSCRATCH: begin cur_val = mscratch; wmask = MSCRATCH_WMASK; end
            CSR_MEPC:     begin cur_val = mepc;     wmask = MEPC_WMASK;     end
            CSR_MCAUSE:   begin cur_val = mcause;   wmask = MCAUSE_WMASK;   end
            CSR_MTVAL:    begin cur_val = mtval;    wmask = MTVAL_WMASK;    end
            default:      ;
        endcase
    end

    // Result is always trimmed to the writable bits
    always_comb begin
        case (req_i.op)
            CSR_WRITE: wr_data = req_i.operand & wmask;
            CSR_SET:   wr_data = (cur_val | req_i.operand) & wmask;
            CSR_CLEAR: wr_data = (cur_val & ~req_i.operand) & wmask;
            default:   wr_data = cur_val;
        endcase
    end

    // mret beats exception beats interrupt entry beats CSR write
    always_ff @(posedge clk) begin
        if (reset) begin
            mstatus  <= '0;  // MIE off
            misa     <= MISA_RESET;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
        end else if (act && trap_i.mret) begin
            mstatus[MSTATUS_MIE_BIT] <= mstatus[MSTATUS_MPIE_BIT];
        end else if (act && trap_i.raise) begin
            mcause                          <= {27'd0, trap_i.code};  // Bit 31 clear
            mstatus[MSTATUS_MPP_LSB +: 2]   <= trap_i.priv;
            mstatus[MSTATUS_MPIE_BIT]       <= mstatus[MSTATUS_MIE_BIT];
            mstatus[MSTATUS_MIE_BIT]        <= 1'b0;
            // ecall returns to itself, others skip the faulting word
            mepc  <= (trap_i.code == EXC_ECALL_M) ? trap_i.pc : trap_i.pc + 32'd4;
            mtval <= (trap_i.code == EXC_ILLEGAL_INSTR) ? trap_i.instr : trap_i.pc;
        end else if (irq_ack_i) begin
            mcause                        <= {1'b1, 26'd0, irq_cause_i};
            mstatus[MSTATUS_MPP_LSB +: 2] <= held_priv;
            mstatus[MSTATUS_MPIE_BIT]     <= mstatus[MSTATUS_MIE_BIT];
            mstatus[MSTATUS_MIE_BIT]      <= 1'b0;  // Drops pending next edge
            mepc                          <= held_pc;
        end else if (act && req_i.op != CSR_NONE) begin
            case (req_i.addr)
                CSR_MSTATUS:  mstatus  <= wr_data;
                CSR_MISA:     misa     <= wr_data;
                CSR_MIE:      mie      <= wr_data;
                CSR_MTVEC:    mtvec    <= wr_data;
                CSR_MSCRATCH: mscratch <= wr_data;
                CSR_MEPC:     mepc     <= wr_data;
                CSR_MCAUSE:   mcause   <= wr_data;
                CSR_MTVAL:    mtval    <= wr_data;
                default:      ;  // Read-only or unknown
            endcase
        end
    end

    // Read port, combinational from the held request
    always_comb begin
        rdata_o = '0;
        if (rd_en) begin
            case (req_i.addr)
                CSR_MVENDORID,
                CSR_MARCHID,
                CSR_MIMPID,
                CSR_MHARTID,
                CSR_MCONFIGPTR: rdata_o = '0;  // Identity regs not implemented
                CSR_MSTATUS:    rdata_o = mstatus;
                CSR_MISA:       rdata_o = misa;
                CSR_MIE:        rdata_o = mie;
                CSR_MTVEC:      rdata_o = mtvec;
                CSR_MSCRATCH:   rdata_o = mscratch;
                CSR_MEPC:       rdata_o = mepc;
                CSR_MCAUSE:     rdata_o = mcause;
                CSR_MTVAL:      rdata_o = mtval;
                CSR_MIP:        rdata_o = mip_i;
                CSR_MCYCLE:     rdata_o = mcycle[31:0];
                CSR_MCYCLEH:    rdata_o = mcycle[63:32];
                CSR_MINSTRET:   rdata_o = minstret[31:0];
                CSR_MINSTRETH:  rdata_o = minstret[63:32];
                default:        rdata_o = '0;
            endcase
        end
    end

    assign rdata_valid_o = rd_en;

    // Performance counters
    always_ff @(posedge clk) begin
        if (reset) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 64'd1;
            if (act) begin
                minstret <= minstret + 64'd1;  // Retired, not killed
            end
        end
    end

endmodule

// File: logic/csr_decoder.sv
/* SYSTEM instruction decoder, CSR request and trap event generation */
module csr_decoder
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] rs1_data_i,
    input  priv_e       priv_i,
    output csr_req_t    req_o,
    output trap_event_t trap_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rs1;
    logic [4:0]  rd;
    logic [11:0] csr_field;
    logic        is_csr;
    logic [31:0] operand;

    // Instruction fields
    assign opcode    = instr_i[6:0];
    assign rd        = instr_i[11:7];
    assign funct3    = instr_i[14:12];
    assign rs1       = instr_i[19:15];
    assign csr_field = instr_i[31:20];

    // funct3 low bits nonzero means one of the six Zicsr forms
    assign is_csr  = (opcode == OPC_SYSTEM) && (funct3[1:0] != 2'b00);
    assign operand = funct3[2] ? {27'd0, rs1} : rs1_data_i;  // Immediate forms use uimm

    always_comb begin
        req_o.op      = CSR_NONE;
        req_o.addr    = csr_field;
        req_o.operand = operand;
        req_o.read    = instr_valid_i && is_csr;
        req_o.rd_zero = (rd == 5'd0);
        if (instr_valid_i && is_csr) begin
            case (funct3[1:0])
                2'b01:   req_o.op = CSR_WRITE;
                2'b10:   req_o.op = (operand == '0) ? CSR_NONE : CSR_SET;   // Zero set is a read
                default: req_o.op = (operand == '0) ? CSR_NONE : CSR_CLEAR;
            endcase
        end
    end

    always_comb begin
        trap_o.raise = 1'b0;
        trap_o.mret  = 1'b0;
        trap_o.code  = EXC_ILLEGAL_INSTR;
        trap_o.pc    = pc_i;
        trap_o.instr = instr_i;
        trap_o.priv  = priv_i;
        if (instr_valid_i && !is_csr) begin
            if (instr_i == INSTR_MRET) begin
                trap_o.mret = 1'b1;
            end else if (instr_i == INSTR_ECALL) begin
                trap_o.raise = 1'b1;
                trap_o.code  = EXC_ECALL_M;
            end else if (instr_i == INSTR_EBREAK) begin
                trap_o.raise = 1'b1;
                trap_o.code  = EXC_BREAKPOINT;
            end else begin
                trap_o.raise = 1'b1;  // Anything else is illegal, code already set
            end
        end
    end

endmodule

// File: logic/csr_pkg.sv
/* Machine CSR addresses, CSR operation encoding, SYSTEM opcode fields,
   per-register write masks, reset values and the CSR request struct */
package csr_pkg;

    // Supported machine-mode CSR addresses
    typedef enum logic [11:0] {
        CSR_MVENDORID  = 12'hF11,
        CSR_MARCHID    = 12'hF12,
        CSR_MIMPID     = 12'hF13,
        CSR_MHARTID    = 12'hF14,
        CSR_MCONFIGPTR = 12'hF15,
        CSR_MSTATUS    = 12'h300,
        CSR_MISA       = 12'h301,
        CSR_MIE        = 12'h304,
        CSR_MTVEC      = 12'h305,
        CSR_MSCRATCH   = 12'h340,
        CSR_MEPC       = 12'h341,
        CSR_MCAUSE     = 12'h342,
        CSR_MTVAL      = 12'h343,
        CSR_MIP        = 12'h344,
        CSR_MCYCLE     = 12'hB00,
        CSR_MINSTRET   = 12'hB02,
        CSR_MCYCLEH    = 12'hB80,
        CSR_MINSTRETH  = 12'hB82
    } csr_addr_e;

    typedef enum logic [1:0] {
        CSR_NONE  = 2'd0,  // Read only, no update
        CSR_WRITE = 2'd1,
        CSR_SET   = 2'd2,
        CSR_CLEAR = 2'd3
    } csr_op_e;

    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Writable bits per register
    localparam logic [31:0] MSTATUS_WMASK  = 32'h007E19AA;
    localparam logic [31:0] MISA_WMASK     = 32'h3C000000;
    localparam logic [31:0] MIE_WMASK      = 32'h00000888;  // MSIE, MTIE, MEIE
    localparam logic [31:0] MTVEC_WMASK    = 32'hFFFFFFFC;  // Direct mode only
    localparam logic [31:0] MSCRATCH_WMASK = 32'hFFFFFFFF;
    localparam logic [31:0] MEPC_WMASK     = 32'hFFFFFFFC;
    localparam logic [31:0] MCAUSE_WMASK   = 32'hFFFFFFFF;
    localparam logic [31:0] MTVAL_WMASK    = 32'hFFFFFFFF;

    localparam logic [31:0] MISA_RESET = 32'h40000100;  // RV32, I extension

    // mstatus field positions
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;  // Two bits wide

    typedef struct packed {
        csr_op_e     op;
        logic [11:0] addr;
        logic [31:0] operand;  // rs1 data or zero-extended uimm
        logic        read;     // CSR instruction, value goes back
        logic        rd_zero;  // Destination is x0
    } csr_req_t;

endpackage

// File: logic/csr_unit_top.sv
/* CSR unit top, decoder into two stage registers into the bank,
   with the interrupt arbiter beside the bank */
module csr_unit_top
    import csr_pkg::*;
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid_i,
    input  logic [31:0] instr_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] rs1_data_i,
    input  priv_e       priv_i,
    input  logic        kill_i,
    input  logic [31:0] irq_i,
    input  logic        irq_ack_i,
    output logic [31:0] csr_rdata_o,
    output logic        rdata_valid_o,
    output logic        irq_pending_o,
    output logic [31:0] mtvec_o,
    output logic [31:0] mepc_o
);

    csr_req_t    dec_req;
    trap_event_t dec_trap;
    csr_req_t    held_req;
    trap_event_t held_trap;
    logic        held_valid;
    logic [31:0] mip;
    logic [31:0] mie;
    logic        global_ie;
    irq_code_e   irq_cause;

    csr_decoder u_decoder (
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .pc_i          (pc_i),
        .rs1_data_i    (rs1_data_i),
        .priv_i        (priv_i),
        .req_o         (dec_req),
        .trap_o        (dec_trap)
    );

    stage_reg #(.PAYLOAD_T(csr_req_t)) u_req_stage (
        .clk     (clk),
        .reset   (reset),
        .kill_i  (kill_i),
        .valid_i (instr_valid_i),
        .data_i  (dec_req),
        .valid_o (held_valid),
        .data_o  (held_req)
    );

    // Same valid as the request stage, so its copy stays open
    stage_reg #(.PAYLOAD_T(trap_event_t)) u_trap_stage (
        .clk     (clk),
        .reset   (reset),
        .kill_i  (kill_i),
        .valid_i (instr_valid_i),
        .data_i  (dec_trap),
        .valid_o (),
        .data_o  (held_trap)
    );

    irq_arbiter u_irq_arbiter (
        .clk         (clk),
        .reset       (reset),
        .irq_i       (irq_i),
        .mie_i       (mie),
        .global_ie_i (global_ie),
        .irq_ack_i   (irq_ack_i),
        .mip_o       (mip),
        .pending_o   (irq_pending_o),
        .cause_o     (irq_cause)
    );

    csr_bank u_csr_bank (
        .clk           (clk),
        .reset         (reset),
        .valid_i       (held_valid),
        .kill_i        (kill_i),
        .req_i         (held_req),
        .trap_i        (held_trap),
        .irq_ack_i     (irq_ack_i),
        .irq_cause_i   (irq_cause),
        .mip_i         (mip),
        .rdata_o       (csr_rdata_o),
        .rdata_valid_o (rdata_valid_o),
        .mie_o         (mie),
        .global_ie_o   (global_ie),
        .mtvec_o       (mtvec_o),
        .mepc_o        (mepc_o)
    );

endmodule

// File: logic/irq_arbiter.sv
/* Interrupt line sampling into mip, pending flag and
   fixed-priority cause selection */
module irq_arbiter
    import trap_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic [31:0] irq_i,
    input  logic [31:0] mie_i,
    input  logic        global_ie_i,
    input  logic        irq_ack_i,
    output logic [31:0] mip_o,
    output logic        pending_o,
    output irq_code_e   cause_o
);

    logic [31:0] enabled;
    logic        any_enabled;

    assign enabled     = mip_o & mie_i;  // Pending and locally enabled
    assign any_enabled = |enabled;

    // One cycle of sampling on the raw lines
    always_ff @(posedge clk) begin
        if (reset) begin
            mip_o <= '0;
        end else begin
            mip_o <= irq_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_o <= 1'b0;
            cause_o   <= IRQ_EXTERNAL;
        end else if (global_ie_i && any_enabled && !irq_ack_i) begin
            pending_o <= 1'b1;
            // External first, then software, then timer
            if (enabled[IRQ_EXTERNAL]) begin
                cause_o <= IRQ_EXTERNAL;
            end else if (enabled[IRQ_SOFTWARE]) begin
                cause_o <= IRQ_SOFTWARE;
            end else if (enabled[IRQ_TIMER]) begin
                cause_o <= IRQ_TIMER;
            end
        end else begin
            pending_o <= 1'b0;  // Cause holds last choice
        end
    end

endmodule

// File: logic/stage_reg.sv
/* Single-entry register stage for any payload type, with valid bit */
module stage_reg #(
    parameter type PAYLOAD_T = logic [31:0]
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     kill_i,
    input  logic     valid_i,
    input  PAYLOAD_T data_i,
    output logic     valid_o,
    output PAYLOAD_T data_o
);

    // Kill at the capture edge flushes the stage
    always_ff @(posedge clk) begin
        if (reset) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i && !kill_i;
        end
    end

    // Payload only moves with a new instruction
    always_ff @(posedge clk) begin
        if (valid_i) begin
            data_o <= data_i;
        end
    end

endmodule

// File: logic/trap_pkg.sv
/* Exception and interrupt cause codes, privilege levels,
   fixed SYSTEM instruction words and the trap event struct */
package trap_pkg;

    typedef enum logic [4:0] {
        EXC_ILLEGAL_INSTR = 5'd2,
        EXC_BREAKPOINT    = 5'd3,
        EXC_ECALL_M       = 5'd11
    } exc_code_e;

    // Values double as bit positions in mip and mie
    typedef enum logic [4:0] {
        IRQ_SOFTWARE = 5'd3,
        IRQ_TIMER    = 5'd7,
        IRQ_EXTERNAL = 5'd11
    } irq_code_e;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_e;

    // Whole-word encodings of the privileged SYSTEM instructions
    localparam logic [31:0] INSTR_ECALL  = 32'h00000073;
    localparam logic [31:0] INSTR_EBREAK = 32'h00100073;
    localparam logic [31:0] INSTR_MRET   = 32'h30200073;

    typedef struct packed {
        logic        raise;  // Synchronous exception
        logic        mret;   // Return from trap
        exc_code_e   code;
        logic [31:0] pc;
        logic [31:0] instr;  // Raw word, goes to mtval when illegal
        priv_e       priv;
    } trap_event_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build the CSR unit testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module csr_unit_tb -o csr_unit_sim

# The simulation exits nonzero on failure, the grep decides the result
sim_output=$(./obj_dir/csr_unit_sim || true)
echo "$sim_output"

if echo "$sim_output" | grep -qx "No errors"; then
    exit 0
fi
exit 1

// File: verif/csr_tb_tasks.svh
/* Instruction encoder and reference model of the machine CSRs,
   included into the CSR unit testbench */
`ifndef CSR_TB_TASKS_SVH
`define CSR_TB_TASKS_SVH

logic [31:0] model_csr [logic [11:0]];   // Writable registers only
logic [31:0] model_mask [logic [11:0]];
int unsigned retired;                    // Issued and not killed

// Zicsr word, field holds rs1 or uimm
function automatic logic [31:0] encode_csr(input logic [2:0] f3, input logic [11:0] addr,
                                           input logic [4:0] field, input logic [4:0] rd);
    return {addr, field, f3, rd, OPC_SYSTEM};
endfunction

function automatic void add_reg(input logic [11:0] addr, input logic [31:0] value,
                                input logic [31:0] mask);
    model_csr[addr]  = value;
    model_mask[addr] = mask;
endfunction

function automatic void reset_model();
    model_csr.delete();
    model_mask.delete();
    add_reg(CSR_MSTATUS, 32'd0, MSTATUS_WMASK);
    add_reg(CSR_MISA, MISA_RESET, MISA_WMASK);
    add_reg(CSR_MIE, 32'd0, MIE_WMASK);
    add_reg(CSR_MTVEC, 32'd0, MTVEC_WMASK);
    add_reg(CSR_MSCRATCH, 32'd0, MSCRATCH_WMASK);
    add_reg(CSR_MEPC, 32'd0, MEPC_WMASK);
    add_reg(CSR_MCAUSE, 32'd0, MCAUSE_WMASK);
    add_reg(CSR_MTVAL, 32'd0, MTVAL_WMASK);
    retired = 0;
endfunction

// Identity, mip with quiet lines and unknown addresses read zero
function automatic logic [31:0] expected_csr(input logic [11:0] addr);
    if (addr == CSR_MINSTRET) begin
        return retired;
    end
    if (model_csr.exists(addr)) begin
        return model_csr[addr];
    end
    return 32'd0;
endfunction

function automatic void apply_csr_op(input logic [11:0] addr, input logic [2:0] f3,
                                     input logic [31:0] operand);
    logic [31:0] old;
    logic [31:0] mask;
    if (!model_csr.exists(addr)) begin
        return;  // Writes elsewhere are dropped
    end
    old  = model_csr[addr];
    mask = model_mask[addr];
    case (f3[1:0])
        2'b01:   model_csr[addr] = operand & mask;
        2'b10:   model_csr[addr] = (operand == 32'd0) ? old : (old | operand) & mask;
        2'b11:   model_csr[addr] = (operand == 32'd0) ? old : (old & ~operand) & mask;
        default: ;
    endcase
endfunction

// Shared part of exception and interrupt entry
function automatic void enter_trap(input logic [31:0] cause, input logic [31:0] epc,
                                   input priv_e priv);
    logic [31:0] st;
    st                        = model_csr[CSR_MSTATUS];
    st[MSTATUS_MPIE_BIT]      = st[MSTATUS_MIE_BIT];
    st[MSTATUS_MIE_BIT]       = 1'b0;
    st[MSTATUS_MPP_LSB +: 2]  = priv;
    model_csr[CSR_MSTATUS]    = st;
    model_csr[CSR_MCAUSE]     = cause;
    model_csr[CSR_MEPC]       = epc;
endfunction

function automatic void restore_mie();
    logic [31:0] st;
    st                     = model_csr[CSR_MSTATUS];
    st[MSTATUS_MIE_BIT]    = st[MSTATUS_MPIE_BIT];  // MPIE itself stays
    model_csr[CSR_MSTATUS] = st;
endfunction

`endif

// File: verif/csr_unit_tb.sv
/* CSR unit testbench, clock and reset, random and directed stimulus,
   model checks by assertions, cycle timeout */
module csr_unit_tb
    import csr_pkg::*;
    import trap_pkg::*;
;

    localparam int NUM_RANDOM = 400;
    // Twice the summed test length, 4 cycles per random pair plus directed tests
    localparam int MAX_CYCLES = 2 * (NUM_RANDOM * 4 + 400);

    localparam logic [11:0] ADDR_LIST [16] = '{
        CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
        CSR_MTVAL, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID, CSR_MCONFIGPTR,
        CSR_MIP, 12'h7C0, 12'h123  // Last two are unlisted
    };

    logic        clk;
    logic        reset;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic [31:0] pc_i;
    logic [31:0] rs1_data_i;
    priv_e       priv_i;
    logic        kill_i;
    logic [31:0] irq_i;
    logic        irq_ack_i;
    logic [31:0] csr_rdata_o;
    logic        rdata_valid_o;
    logic        irq_pending_o;
    logic [31:0] mtvec_o;
    logic [31:0] mepc_o;
    int          cycles = 0;

    `include "csr_tb_tasks.svh"

    csr_unit_top csr_unit_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout, the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    task automatic stop_with_failure(input string msg);
        $display("Fail at time %0t: %s", $time, msg);
        $display("Errors found");
        $fatal(1, "Stopping at the first failed check");
    endtask

    // Read data must be zero whenever it is not marked valid
    zero_when_invalid: assert property (@(posedge clk) disable iff (reset)
        !rdata_valid_o |-> (csr_rdata_o == 32'd0))
        else stop_with_failure("csr_rdata_o nonzero while rdata_valid_o is low");

    task automatic step_clock();
        @(posedge clk);
        #2;
    endtask

    // Issue cycle, then held cycle with kill and ack, sampled at the falling edge
    task automatic issue_instr(input logic [31:0] instr, input logic [31:0] rs1_val,
                               input logic [31:0] pc, input logic kill, input logic ack,
                               output logic [31:0] rdata, output logic rvalid);
        instr_valid_i = 1'b1;
        instr_i       = instr;
        rs1_data_i    = rs1_val;
        pc_i          = pc;
        step_clock();
        instr_valid_i = 1'b0;
        kill_i        = kill;
        irq_ack_i     = ack;
        @(negedge clk);
        rdata  = csr_rdata_o;
        rvalid = rdata_valid_o;
        step_clock();  // Bank has updated
        kill_i    = 1'b0;
        irq_ack_i = 1'b0;
        if (!kill) begin
            retired++;
        end
    endtask

    task automatic csr_access(input logic [2:0] f3, input logic [11:0] addr,
                              input logic [31:0] value, input logic [4:0] rd);
        logic [31:0] operand;
        logic [4:0]  field;
        logic [31:0] exp_data;
        logic [31:0] got;
        logic        valid;
        operand  = f3[2] ? {27'd0, value[4:0]} : value;  // uimm is zero-extended
        field    = f3[2] ? value[4:0] : 5'd5;
        exp_data = (rd != 5'd0) ? expected_csr(addr) : 32'd0;  // Old value comes back
        issue_instr(encode_csr(f3, addr, field, rd), value, 32'h1000, 1'b0, 1'b0, got, valid);
        assert (valid === (rd != 5'd0))
            else stop_with_failure($sformatf("rdata_valid_o %b for rd %0d", valid, rd));
        assert (got === exp_data)
            else stop_with_failure($sformatf("CSR %h read %h, expected %h", addr, got, exp_data));
        apply_csr_op(addr, f3, operand);
    endtask

    task automatic check_csr(input logic [11:0] addr);
        csr_access(3'b010, addr, 32'd0, 5'd1);  // CSRRS with zero, read only
    endtask

    task automatic run_random_csr();
        logic [31:0] rnd;
        logic [31:0] value;
        logic [11:0] addr;
        logic [2:0]  f3;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd   = $urandom();
            value = $urandom();
            addr  = ADDR_LIST[rnd[3:0]];
            f3    = {rnd[4], (rnd[6:5] == 2'b00) ? 2'b01 : rnd[6:5]};
            if (rnd[9:7] == 3'd0) begin
                value = 32'd0;  // Zero set and clear reduce to reads
            end
            csr_access(f3, addr, value, rnd[14:10]);
            check_csr(addr);
            assert (mtvec_o === expected_csr(CSR_MTVEC))
                else stop_with_failure("mtvec_o differs from the model");
        end
    endtask

    task automatic run_counters_and_kill();
        logic [31:0] c0;
        logic [31:0] c1;
        logic [31:0] rnd;
        logic        valid;
        issue_instr(encode_csr(3'b010, CSR_MCYCLE, 5'd0, 5'd1), '0, 32'h200, 1'b0, 1'b0,
                    c0, valid);
        issue_instr(encode_csr(3'b010, CSR_MCYCLE, 5'd0, 5'd1), '0, 32'h204, 1'b0, 1'b0,
                    c1, valid);
        assert (c1 - c0 === 32'd2)
            else stop_with_failure($sformatf("mcycle went from %0d to %0d", c0, c1));
        check_csr(CSR_MCYCLEH);  // Short run, upper half still zero
        check_csr(CSR_MINSTRET);
        check_csr(CSR_MINSTRETH);
        rnd = $urandom();
        issue_instr(encode_csr(3'b001, CSR_MSCRATCH, 5'd5, 5'd1), rnd, 32'h208, 1'b1, 1'b0,
                    c0, valid);
        assert (!valid && c0 === 32'd0)
            else stop_with_failure("killed read returned valid data");
        issue_instr(INSTR_ECALL, '0, 32'h20C, 1'b1, 1'b0, c0, valid);  // Killed ecall
        check_csr(CSR_MSCRATCH);
        check_csr(CSR_MCAUSE);
        check_csr(CSR_MSTATUS);
        check_csr(CSR_MINSTRET);
    endtask

    task automatic issue_mret();
        logic [31:0] got;
        logic        valid;
        issue_instr(INSTR_MRET, '0, 32'h300, 1'b0, 1'b0, got, valid);
        assert (!valid) else stop_with_failure("mret marked read data valid");
        restore_mie();
        check_csr(CSR_MSTATUS);
    endtask

    task automatic take_exception(input logic [31:0] instr, input exc_code_e code,
                                  input priv_e priv);
        logic [31:0] rnd;
        logic [31:0] pc;
        logic [31:0] got;
        logic        valid;
        rnd    = $urandom();
        pc     = {rnd[31:2], 2'b00};
        priv_i = priv;
        issue_instr(instr, '0, pc, 1'b0, 1'b0, got, valid);
        priv_i = PRIV_MACHINE;
        assert (!valid) else stop_with_failure("trapping instruction marked read data valid");
        // ecall returns to itself, others to the next word
        enter_trap({27'd0, code}, (code == EXC_ECALL_M) ? pc : pc + 32'd4, priv);
        model_csr[CSR_MTVAL] = (code == EXC_ILLEGAL_INSTR) ? instr : pc;
        assert (mepc_o === expected_csr(CSR_MEPC))
            else stop_with_failure($sformatf("mepc_o %h after trap at pc %h", mepc_o, pc));
        check_csr(CSR_MCAUSE);
        check_csr(CSR_MTVAL);
        check_csr(CSR_MEPC);
        check_csr(CSR_MSTATUS);
    endtask

    task automatic run_exceptions();
        logic [31:0] rnd;
        csr_access(3'b110, CSR_MSTATUS, 32'd8, 5'd1);  // MIE on, MPIE picks it up
        take_exception(INSTR_ECALL, EXC_ECALL_M, PRIV_MACHINE);
        issue_mret();
        csr_access(3'b111, CSR_MSTATUS, 32'd8, 5'd1);  // MIE off
        rnd = $urandom();
        take_exception({rnd[31:7], 7'b0110011}, EXC_ILLEGAL_INSTR, PRIV_USER);
        issue_mret();
        take_exception(32'h10500073, EXC_ILLEGAL_INSTR, PRIV_MACHINE);  // wfi unsupported
        issue_mret();
    endtask

    task automatic expect_no_pending(input logic [31:0] lines);
        irq_i = lines;
        repeat (3) step_clock();
        assert (irq_pending_o === 1'b0)
            else stop_with_failure("irq_pending_o high with the interrupt disabled");
        irq_i = '0;
        repeat (2) step_clock();
    endtask

    task automatic take_interrupt(input logic [31:0] lines, input irq_code_e cause);
        logic [31:0] rnd;
        logic [31:0] pc;
        logic [31:0] got;
        logic        valid;
        irq_i = lines;
        step_clock();  // Lines now in mip
        assert (irq_pending_o === 1'b0) else stop_with_failure("irq_pending_o rose early");
        step_clock();
        assert (irq_pending_o === 1'b1)
            else stop_with_failure("irq_pending_o low two cycles after the line rose");
        rnd = $urandom();
        pc  = {rnd[31:2], 2'b00};
        // Acknowledge while a plain mscratch read is held
        issue_instr(encode_csr(3'b010, CSR_MSCRATCH, 5'd0, 5'd1), '0, pc, 1'b0, 1'b1,
                    got, valid);
        assert (valid && got === expected_csr(CSR_MSCRATCH))
            else stop_with_failure("read held during acknowledge returned wrong data");
        enter_trap({1'b1, 26'd0, cause}, pc, PRIV_MACHINE);
        assert (irq_pending_o === 1'b0) else stop_with_failure("irq_pending_o stayed high");
        assert (mepc_o === pc)
            else stop_with_failure($sformatf("mepc_o %h, held pc %h", mepc_o, pc));
        irq_i = '0;
        check_csr(CSR_MCAUSE);
        check_csr(CSR_MEPC);
        check_csr(CSR_MSTATUS);
        issue_mret();
    endtask

    task automatic run_interrupts();
        csr_access(3'b001, CSR_MIE, 32'h00000888, 5'd1);
        csr_access(3'b111, CSR_MSTATUS, 32'd8, 5'd1);  // Global enable off
        expect_no_pending(32'h00000888);
        csr_access(3'b110, CSR_MSTATUS, 32'd8, 5'd1);
        csr_access(3'b001, CSR_MIE, 32'h00000008, 5'd1);  // Software only
        expect_no_pending(32'h00000880);
        csr_access(3'b001, CSR_MIE, 32'h00000888, 5'd1);
        take_interrupt(32'h00000888, IRQ_EXTERNAL);
        take_interrupt(32'h00000088, IRQ_SOFTWARE);
        take_interrupt(32'h00000080, IRQ_TIMER);
    endtask

    initial begin
        void'($urandom(32'ha92c));
        reset         = 1'b1;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        pc_i          = '0;
        rs1_data_i    = '0;
        priv_i        = PRIV_MACHINE;
        kill_i        = 1'b0;
        irq_i         = '0;
        irq_ack_i     = 1'b0;
        reset_model();
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;
        assert (!rdata_valid_o && !irq_pending_o && !csr_unit_top_i.held_valid)
            else stop_with_failure("outputs not cleared by reset");
        run_random_csr();
        run_counters_and_kill();
        run_exceptions();
        run_interrupts();
        check_csr(CSR_MINSTRET);  // Every issued, unkilled instruction counted
        $display("No errors");
        $finish;
    end

endmodule
